// File: axi_lite_ram.sv
`timescale 1ns/1ps
`default_nettype none

module axi_lite_ram
   import soc_bus_pkg::*;
(
   input  logic     clk,
   input  logic     rstn,
   input  axi_req_t req,
   output axi_rsp_t rsp
);

   logic [31:0]       mem [RAM_WORDS];
   logic              r_pend;
   logic              b_pend;
   logic              aw_hold;
   logic              w_hold;
   logic              ar_fire;
   logic              aw_fire;
   logic              w_fire;
   logic [RAM_AW-1:0] aw_idx;
   logic [31:0]       rd_data;
   axi_w_t            w_buf;

   assign ar_fire = req.ar_valid & rsp.ar_ready;
   assign aw_fire = req.aw_valid & rsp.aw_ready;
   assign w_fire  = req.w_valid & rsp.w_ready;

   always_ff @(posedge clk) begin
      if (rstn) begin
         r_pend <= 1'b0;
         b_pend <= 1'b0;
         aw_hold <= 1'b0;
         w_hold <= 1'b0;
      end else begin
         if (ar_fire)
            r_pend <= 1'b1;
         else if (req.r_ready)
            r_pend <= 1'b0;

         if (aw_fire)
            aw_hold <= 1'b1;
         if (w_fire)
            w_hold <= 1'b1;

         // both halves held, commit and answer
         if (aw_hold && w_hold) begin
            aw_hold <= 1'b0;
            w_hold <= 1'b0;
            b_pend <= 1'b1;
         end else if (req.b_ready) begin
            b_pend <= 1'b0;
         end
      end
   end

   always_ff @(posedge clk) begin
      if (ar_fire)
         rd_data <= mem[req.ar.addr[RAM_AW+1:2]];
      if (aw_fire)
         aw_idx <= req.aw.addr[RAM_AW+1:2];
      if (w_fire)
         w_buf <= req.w;
      if (aw_hold && w_hold) begin
         for (int i = 0; i < 4; i++) begin
            if (w_buf.strb[i])
               mem[aw_idx][8*i +: 8] <= w_buf.data[8*i +: 8];
         end
      end
   end

   always_comb begin
      rsp.ar_ready = !r_pend;
      rsp.aw_ready = !aw_hold & !b_pend;
      rsp.w_ready  = !w_hold & !b_pend;
      rsp.r_valid  = r_pend;
      rsp.r.data   = rd_data;
      rsp.r.resp   = RESP_OKAY;
      rsp.b_valid  = b_pend;
      rsp.b.resp   = RESP_OKAY;
   end

endmodule

`default_nettype wire

// File: axi_lite_router.sv
`timescale 1ns/1ps
`default_nettype none

module axi_lite_router
   import soc_bus_pkg::*;
(
   input  logic     clk,
   input  logic     rstn,
   input  axi_req_t core_req,
   output axi_rsp_t core_rsp,
   output axi_req_t mem_req,
   input  axi_rsp_t mem_rsp,
   output axi_req_t uart_req,
   input  axi_rsp_t uart_rsp
);

   typedef enum logic [1:0] {R_IDLE, R_ADDR, R_DATA, R_RESP} rd_state_t;
   typedef enum logic [1:0] {W_IDLE, W_SEND, W_BWAIT, W_RESP} wr_state_t;

   rd_state_t  rd_state;
   logic       rd_sel;
   axi_ar_t    rd_ar;
   axi_r_t     rd_r;
   axi_rsp_t   rd_rsp;
   core_addr_u rd_addr;

   wr_state_t  wr_state;
   logic       wr_sel;
   logic       aw_hold;
   logic       w_hold;
   logic       aw_fire;
   logic       w_fire;
   axi_aw_t    wr_aw;
   axi_w_t     wr_w;
   axi_b_t     wr_b;
   axi_rsp_t   wr_rsp;
   core_addr_u wr_addr;

   // keep only the offset the chosen slave decodes
   function automatic logic [31:0] trim_addr(core_addr_u a);
      if (a.uart_view.tag == UART_TAG)
         return {28'd0, a.uart_view.reg_sel};
      return {20'd0, a.mem_view.offset};
   endfunction

   assign rd_addr = core_req.ar.addr;
   assign wr_addr = core_req.aw.addr;
   assign rd_rsp  = rd_sel ? uart_rsp : mem_rsp;
   assign wr_rsp  = wr_sel ? uart_rsp : mem_rsp;
   assign aw_fire = core_req.aw_valid & core_rsp.aw_ready;
   assign w_fire  = core_req.w_valid & core_rsp.w_ready;

   ////////////////////
   // read path

   always_ff @(posedge clk) begin
      if (rstn) begin
         rd_state <= R_IDLE;
         rd_sel <= 1'b0;
      end else begin
         case (rd_state)
            R_IDLE: if (core_req.ar_valid) begin
               rd_sel <= (rd_addr.uart_view.tag == UART_TAG);
               rd_state <= R_ADDR;
            end
            R_ADDR: if (rd_rsp.ar_ready) rd_state <= R_DATA;
            R_DATA: if (rd_rsp.r_valid) rd_state <= R_RESP;
            R_RESP: if (core_req.r_ready) rd_state <= R_IDLE;
            default: rd_state <= R_IDLE;
         endcase
      end
   end

   always_ff @(posedge clk) begin
      if (rd_state == R_IDLE && core_req.ar_valid) begin
         rd_ar.addr <= trim_addr(rd_addr);
         rd_ar.prot <= core_req.ar.prot;
      end
      if (rd_state == R_DATA && rd_rsp.r_valid)
         rd_r <= rd_rsp.r;
   end

   ////////////////////
   // write path

   // hold flags mean taken from the core in W_IDLE, still owed to the slave in W_SEND
   always_ff @(posedge clk) begin
      if (rstn) begin
         wr_state <= W_IDLE;
         wr_sel <= 1'b0;
         aw_hold <= 1'b0;
         w_hold <= 1'b0;
      end else begin
         case (wr_state)
            W_IDLE: begin
               if (aw_fire) begin
                  aw_hold <= 1'b1;
                  wr_sel <= (wr_addr.uart_view.tag == UART_TAG);
               end
               if (w_fire)
                  w_hold <= 1'b1;
               if ((aw_hold | aw_fire) & (w_hold | w_fire)) begin
                  aw_hold <= 1'b1;
                  w_hold <= 1'b1;
                  wr_state <= W_SEND;
               end
            end
            W_SEND: begin
               if (wr_rsp.aw_ready)
                  aw_hold <= 1'b0;
               if (wr_rsp.w_ready)
                  w_hold <= 1'b0;
               if ((!aw_hold | wr_rsp.aw_ready) & (!w_hold | wr_rsp.w_ready))
                  wr_state <= W_BWAIT;
            end
            W_BWAIT: if (wr_rsp.b_valid) wr_state <= W_RESP;
            W_RESP: if (core_req.b_ready) wr_state <= W_IDLE;
            default: wr_state <= W_IDLE;
         endcase
      end
   end

   always_ff @(posedge clk) begin
      if (aw_fire) begin
         wr_aw.addr <= trim_addr(wr_addr);
         wr_aw.prot <= core_req.aw.prot;
      end
      if (w_fire)
         wr_w <= core_req.w;
      if (wr_state == W_BWAIT && wr_rsp.b_valid)
         wr_b <= wr_rsp.b;
   end

   ////////////////////
   // channel outputs

   always_comb begin
      core_rsp.ar_ready = (rd_state == R_IDLE);
      core_rsp.r_valid  = (rd_state == R_RESP);
      core_rsp.r        = rd_r;
      core_rsp.aw_ready = (wr_state == W_IDLE) & !aw_hold;
      core_rsp.w_ready  = (wr_state == W_IDLE) & !w_hold;
      core_rsp.b_valid  = (wr_state == W_RESP);
      core_rsp.b        = wr_b;
   end

   always_comb begin
      mem_req.ar        = rd_ar;
      mem_req.aw        = wr_aw;
      mem_req.w         = wr_w;
      mem_req.ar_valid  = (rd_state == R_ADDR) & !rd_sel;
      mem_req.r_ready   = (rd_state == R_DATA) & !rd_sel;
      mem_req.aw_valid  = (wr_state == W_SEND) & aw_hold & !wr_sel;
      mem_req.w_valid   = (wr_state == W_SEND) & w_hold & !wr_sel;
      mem_req.b_ready   = (wr_state == W_BWAIT) & !wr_sel;

      uart_req.ar       = rd_ar;
      uart_req.aw       = wr_aw;
      uart_req.w        = wr_w;
      uart_req.ar_valid = (rd_state == R_ADDR) & rd_sel;
      uart_req.r_ready  = (rd_state == R_DATA) & rd_sel;
      uart_req.aw_valid = (wr_state == W_SEND) & aw_hold & wr_sel;
      uart_req.w_valid  = (wr_state == W_SEND) & w_hold & wr_sel;
      uart_req.b_ready  = (wr_state == W_BWAIT) & wr_sel;
   end

endmodule

`default_nettype wire

// File: run_sim.sh
#!/bin/sh
# build and run the testbench with Verilator, from the project root

cd "$(dirname "$0")" || exit 1

verilator --binary -j 0 --top-module tb_soc_bus_top -f soc_bus_top.f \
   -o tb_soc_bus_top > build.log 2>&1
if [ $? -ne 0 ]; then
   cat build.log
   echo "verilator build failed"
   exit 1
fi

./obj_dir/tb_soc_bus_top > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
   echo "simulation exited with status $status"
   exit 1
fi

if grep -q "Simulation failed" sim.log; then
   exit 1
fi
exit 0

// File: soc_bus_pkg.sv
`default_nettype none

package soc_bus_pkg;

   localparam logic [1:0] RESP_OKAY = 2'b00;
   localparam logic [1:0] RESP_SLVERR = 2'b10;

   localparam logic [7:0] UART_TAG = 8'h7F;
   localparam int RAM_WORDS = 1024;
   localparam int RAM_AW = $clog2(RAM_WORDS);

   localparam logic [3:0] UART_REG_RX = 4'h0;
   localparam logic [3:0] UART_REG_TX = 4'h4;
   localparam logic [3:0] UART_REG_STATUS = 4'h8;
   localparam logic [3:0] UART_REG_CTRL = 4'hC;

   localparam int DIV_WIDTH = 16;
   localparam logic [DIV_WIDTH-1:0] DEFAULT_DIVISOR = 16;

   ////////////////////
   // axi-lite channels

   typedef struct packed {
      logic [31:0] addr;
      logic [2:0]  prot;
   } axi_ar_t;

   typedef struct packed {
      logic [31:0] addr;
      logic [2:0]  prot;
   } axi_aw_t;

   typedef struct packed {
      logic [31:0] data;
      logic [3:0]  strb;
   } axi_w_t;

   typedef struct packed {
      logic [31:0] data;
      logic [1:0]  resp;
   } axi_r_t;

   typedef struct packed {
      logic [1:0] resp;
   } axi_b_t;

   typedef struct packed {
      axi_ar_t ar;
      logic    ar_valid;
      axi_aw_t aw;
      logic    aw_valid;
      axi_w_t  w;
      logic    w_valid;
      logic    r_ready;
      logic    b_ready;
   } axi_req_t;

   typedef struct packed {
      logic   ar_ready;
      logic   aw_ready;
      logic   w_ready;
      axi_r_t r;
      logic   r_valid;
      axi_b_t b;
      logic   b_valid;
   } axi_rsp_t;

   // one core address, seen by either slave
   typedef union packed {
      struct packed {
         logic [7:0]  tag;
         logic [11:0] unused;
         logic [11:0] offset;
      } mem_view;
      struct packed {
         logic [7:0]  tag;
         logic [19:0] unused;
         logic [3:0]  reg_sel;
      } uart_view;
   } core_addr_u;

   ////////////////////
   // uart engine link

   typedef struct packed {
      logic [DIV_WIDTH-1:0] divisor;
      logic                 tx_start;
      logic [7:0]           tx_byte;
   } uart_ctrl_t;

   typedef struct packed {
      logic       tx_busy;
      logic       rx_strobe;
      logic [7:0] rx_byte;
      logic       rx_frame_err;
   } uart_stat_t;

endpackage

`default_nettype wire

// File: soc_bus_top.f
soc_bus_pkg.sv
uart_core.sv
uart_regs.sv
axi_lite_ram.sv
axi_lite_router.sv
soc_bus_top.sv
tb_soc_bus_top.sv

// File: soc_bus_top.sv
`timescale 1ns/1ps
`default_nettype none

module soc_bus_top
   import soc_bus_pkg::*;
(
   input  logic     clk,
   input  logic     rstn,
   input  axi_req_t core_req,
   output axi_rsp_t core_rsp,
   output logic     uart_txd,
   input  logic     uart_rxd
);

   axi_req_t   mem_req;
   axi_rsp_t   mem_rsp;
   axi_req_t   uart_req;
   axi_rsp_t   uart_rsp;
   uart_ctrl_t uart_ctrl;
   uart_stat_t uart_stat;

   axi_lite_router router_i (
      .clk      (clk),
      .rstn     (rstn),
      .core_req (core_req),
      .core_rsp (core_rsp),
      .mem_req  (mem_req),
      .mem_rsp  (mem_rsp),
      .uart_req (uart_req),
      .uart_rsp (uart_rsp)
   );

   axi_lite_ram ram_i (
      .clk  (clk),
      .rstn (rstn),
      .req  (mem_req),
      .rsp  (mem_rsp)
   );

   // register block steers the serial engine
   uart_regs uart_regs_i (
      .clk  (clk),
      .rstn (rstn),
      .req  (uart_req),
      .rsp  (uart_rsp),
      .ctrl (uart_ctrl),
      .stat (uart_stat)
   );

   uart_core uart_core_i (
      .clk  (clk),
      .rstn (rstn),
      .ctrl (uart_ctrl),
      .stat (uart_stat),
      .txd  (uart_txd),
      .rxd  (uart_rxd)
   );

endmodule

`default_nettype wire

// File: tb_soc_bus_top.sv
`timescale 1ns/1ps
`default_nettype none

module tb_soc_bus_top
   import soc_bus_pkg::*;
();

   localparam int CLK_NS = 40;
   localparam int UART_DIV = 4;
   localparam int FRAMES = 4;
   localparam int BUS_OPS = 250;
   // serial frames with their idle gaps, then bus traffic, then double it
   localparam int WATCHDOG_NS =
      2 * (FRAMES * 20 * UART_DIV * CLK_NS + BUS_OPS * 10 * CLK_NS + 10 * CLK_NS);
   localparam axi_b_t B_OKAY = '{resp: RESP_OKAY};
   localparam axi_b_t B_SLVERR = '{resp: RESP_SLVERR};
   localparam logic [31:0] SPARE_DIV = 32'd24;

   logic        clk = 1'b0;
   logic        rstn;
   axi_req_t    core_req;
   axi_rsp_t    core_rsp;
   logic        uart_txd;
   logic        uart_rxd;
   logic        loopback;
   logic        rxd_drive;
   logic [31:0] model [RAM_WORDS];
   string       test_name;
   int          n_checks;
   int          n_errors;

   always #(CLK_NS / 2) clk = ~clk;

   // serial input either echoes the transmitter or follows the testbench
   assign uart_rxd = loopback ? uart_txd : rxd_drive;

   soc_bus_top soc_bus_top_i (
      .clk      (clk),
      .rstn     (rstn),
      .core_req (core_req),
      .core_rsp (core_rsp),
      .uart_txd (uart_txd),
      .uart_rxd (uart_rxd)
   );

   ////////////////////
   // checks

   task automatic check_data(input string what, input logic [31:0] exp, input axi_r_t act);
      n_checks++;
      if (act.data !== exp) begin
         n_errors++;
         $display("ERROR %s %s: expected %h, actual %h", test_name, what, exp, act.data);
      end
   endtask

   task automatic check_resp(input string what, input axi_b_t exp, input axi_b_t act);
      n_checks++;
      if (act.resp !== exp.resp) begin
         n_errors++;
         $display("ERROR %s %s: expected %b, actual %b", test_name, what, exp.resp, act.resp);
      end
   endtask

   task automatic note_failure(input string msg);
      n_errors++;
      $display("ERROR %s: %s", test_name, msg);
   endtask

   function automatic logic [31:0] merge_bytes(input logic [31:0] old, input logic [31:0] nw,
                                               input logic [3:0] strb);
      logic [31:0] res;
      res = old;
      for (int b = 0; b < 4; b++) begin
         if (strb[b])
            res[8*b +: 8] = nw[8*b +: 8];
      end
      return res;
   endfunction

   function automatic logic [31:0] uart_addr(input logic [3:0] sel);
      return {UART_TAG, 20'd0, sel};
   endfunction

   function automatic logic [31:0] status_word(input logic ovr, input logic ferr,
                                               input logic rxv, input logic busy);
      return {28'd0, ovr, ferr, rxv, busy};
   endfunction

   ////////////////////
   // bus and serial drivers

   task automatic axi_read(input logic [31:0] addr, output axi_r_t rd);
      @(posedge clk);
      #2;
      core_req.ar.addr = addr;
      core_req.ar.prot = 3'b000;
      core_req.ar_valid = 1'b1;
      core_req.r_ready = 1'b1;
      @(negedge clk);
      while (!core_rsp.ar_ready)
         @(negedge clk);
      @(posedge clk);
      #2;
      core_req.ar_valid = 1'b0;
      @(negedge clk);
      while (!core_rsp.r_valid)
         @(negedge clk);
      rd = core_rsp.r;
      @(posedge clk);
      #2;
      core_req.r_ready = 1'b0;
   endtask

   // w_delay holds the data channel back by that many cycles
   task automatic axi_write(input logic [31:0] addr, input logic [31:0] data,
                            input logic [3:0] strb, input int w_delay, output axi_b_t wb);
      fork
         begin
            @(posedge clk);
            #2;
            core_req.aw.addr = addr;
            core_req.aw.prot = 3'b000;
            core_req.aw_valid = 1'b1;
            @(negedge clk);
            while (!core_rsp.aw_ready)
               @(negedge clk);
            @(posedge clk);
            #2;
            core_req.aw_valid = 1'b0;
         end
         begin
            repeat (w_delay + 1) @(posedge clk);
            #2;
            core_req.w = '{data: data, strb: strb};
            core_req.w_valid = 1'b1;
            @(negedge clk);
            while (!core_rsp.w_ready)
               @(negedge clk);
            @(posedge clk);
            #2;
            core_req.w_valid = 1'b0;
         end
      join
      core_req.b_ready = 1'b1;
      @(negedge clk);
      while (!core_rsp.b_valid)
         @(negedge clk);
      wb = core_rsp.b;
      @(posedge clk);
      #2;
      core_req.b_ready = 1'b0;
   endtask

   task automatic ram_write(input logic [31:0] addr, input logic [31:0] data,
                            input logic [3:0] strb);
      axi_b_t wb;
      axi_write(addr, data, strb, 0, wb);
      check_resp("ram write resp", B_OKAY, wb);
      model[addr[11:2]] = merge_bytes(model[addr[11:2]], data, strb);
   endtask

   task automatic ram_check(input logic [31:0] addr);
      axi_r_t rd;
      axi_read(addr, rd);
      check_data("ram read", model[addr[11:2]], rd);
      check_resp("ram read resp", B_OKAY, axi_b_t'(rd.resp));
   endtask

   // start, 8 data bits lsb first, stop, then an idle gap
   task automatic drive_frame(input logic [7:0] data, input logic stop_bit);
      logic [9:0] bits;
      bits = {stop_bit, data, 1'b0};
      for (int k = 0; k < 10; k++) begin
         @(posedge clk);
         #2;
         rxd_drive = bits[k];
         repeat (UART_DIV - 1) @(posedge clk);
      end
      @(posedge clk);
      #2;
      rxd_drive = 1'b1;
      repeat (4 * UART_DIV) @(posedge clk);
   endtask

   ////////////////////
   // directed tests

   task automatic reset_state();
      test_name = "reset_state";
      @(negedge clk);
      if (!core_rsp.ar_ready || !core_rsp.aw_ready || !core_rsp.w_ready)
         note_failure("core readys not high after reset");
      if (core_rsp.r_valid || core_rsp.b_valid)
         note_failure("core response valid high after reset");
      if (uart_txd !== 1'b1)
         note_failure("uart_txd not idle high after reset");
   endtask

   task automatic ram_strobes();
      test_name = "ram_strobes";
      for (int i = 0; i < 16; i++)
         ram_write(32'h0000_0200 + 32'(4 * i), $urandom(), 4'hF);
      for (int i = 0; i < 16; i++)
         ram_write(32'h0000_0200 + 32'(4 * i), $urandom(), i[3:0]);
      for (int i = 0; i < 16; i++)
         ram_check(32'h0000_0200 + 32'(4 * i));
   endtask

   task automatic address_decode();
      axi_r_t rd;
      axi_b_t wb;
      test_name = "address_decode";
      for (int i = 0; i < 4; i++)
         ram_write(32'(4 * i), $urandom(), 4'hF);
      ram_write(32'h0000_0004, $urandom(), 4'hF);
      ram_check(32'h0000_1004);
      ram_check(32'h0000_0004);
      ram_write(32'hA500_2008, $urandom(), 4'hF);
      ram_check(32'h0000_0008);
      ram_check(32'h0000_3008);
      // uart region accesses at the same low offsets
      axi_read(uart_addr(UART_REG_STATUS), rd);
      check_data("status idle", status_word(1'b0, 1'b0, 1'b0, 1'b0), rd);
      axi_read(uart_addr(UART_REG_CTRL), rd);
      check_data("ctrl reset value", 32'(DEFAULT_DIVISOR), rd);
      axi_write(uart_addr(UART_REG_CTRL), SPARE_DIV, 4'hF, 0, wb);
      check_resp("ctrl write", B_OKAY, wb);
      axi_read(uart_addr(UART_REG_CTRL), rd);
      check_data("ctrl readback", SPARE_DIV, rd);
      for (int i = 0; i < 4; i++)
         ram_check(32'(4 * i));
   endtask

   task automatic uart_loopback();
      axi_r_t     rd;
      axi_b_t     wb;
      logic [7:0] tx_byte;
      int         polls;
      test_name = "uart_loopback";
      tx_byte = 8'($urandom());
      loopback = 1'b1;
      axi_write(uart_addr(UART_REG_CTRL), 32'(UART_DIV), 4'hF, 0, wb);
      check_resp("ctrl write", B_OKAY, wb);
      axi_write(uart_addr(UART_REG_TX), {24'd0, tx_byte}, 4'hF, 0, wb);
      check_resp("tx write", B_OKAY, wb);
      // transmitter still busy with the first byte
      axi_write(uart_addr(UART_REG_TX), {24'd0, ~tx_byte}, 4'hF, 0, wb);
      check_resp("tx write while busy", B_SLVERR, wb);
      polls = 0;
      rd.data = '0;
      while (!rd.data[1] && polls < 60) begin
         axi_read(uart_addr(UART_REG_STATUS), rd);
         polls++;
      end
      if (!rd.data[1])
         note_failure("rx_valid never set after the loopback frame");
      axi_read(uart_addr(UART_REG_RX), rd);
      check_data("rx byte", {24'd0, tx_byte}, rd);
      check_resp("rx read", B_OKAY, axi_b_t'(rd.resp));
      axi_read(uart_addr(UART_REG_RX), rd);
      check_resp("second rx read", B_SLVERR, axi_b_t'(rd.resp));
      loopback = 1'b0;
   endtask

   task automatic uart_errors();
      axi_r_t     rd;
      axi_b_t     wb;
      logic [7:0] first;
      logic [7:0] second;
      test_name = "uart_errors";
      axi_read(uart_addr(UART_REG_TX), rd);
      check_resp("tx read", B_SLVERR, axi_b_t'(rd.resp));
      axi_write(uart_addr(UART_REG_RX), 32'h55, 4'hF, 0, wb);
      check_resp("rx write", B_SLVERR, wb);
      axi_write(uart_addr(UART_REG_STATUS), 32'h55, 4'hF, 0, wb);
      check_resp("status write", B_SLVERR, wb);

      // low stop bit
      first = 8'($urandom());
      drive_frame(first, 1'b0);
      axi_read(uart_addr(UART_REG_STATUS), rd);
      check_data("status after bad stop", status_word(1'b0, 1'b1, 1'b1, 1'b0), rd);
      axi_read(uart_addr(UART_REG_RX), rd);
      check_data("rx after bad stop", {24'd0, first}, rd);
      check_resp("rx after bad stop", B_OKAY, axi_b_t'(rd.resp));
      axi_read(uart_addr(UART_REG_STATUS), rd);
      check_data("status after rx read", status_word(1'b0, 1'b0, 1'b0, 1'b0), rd);

      // overrun keeps the newer byte
      first = 8'($urandom());
      second = 8'($urandom());
      drive_frame(first, 1'b1);
      drive_frame(second, 1'b1);
      axi_read(uart_addr(UART_REG_STATUS), rd);
      check_data("status after overrun", status_word(1'b1, 1'b0, 1'b1, 1'b0), rd);
      axi_read(uart_addr(UART_REG_RX), rd);
      check_data("rx after overrun", {24'd0, second}, rd);
      axi_read(uart_addr(UART_REG_STATUS), rd);
      check_data("status cleared", status_word(1'b0, 1'b0, 1'b0, 1'b0), rd);
   endtask

   task automatic bus_backpressure();
      axi_r_t      rd;
      axi_r_t      held;
      axi_b_t      wb;
      logic [31:0] ra;
      logic [31:0] wa;
      logic [31:0] data;
      test_name = "bus_backpressure";
      ra = 32'h0000_0300;
      ram_write(ra, $urandom(), 4'hF);
      @(posedge clk);
      #2;
      core_req.ar.addr = ra;
      core_req.ar_valid = 1'b1;
      core_req.r_ready = 1'b0;
      @(negedge clk);
      while (!core_rsp.ar_ready)
         @(negedge clk);
      @(posedge clk);
      #2;
      core_req.ar_valid = 1'b0;
      @(negedge clk);
      while (!core_rsp.r_valid)
         @(negedge clk);
      held = core_rsp.r;
      repeat (6) begin
         @(negedge clk);
         if (!core_rsp.r_valid)
            note_failure("r_valid dropped while r_ready was low");
         if (core_rsp.ar_ready)
            note_failure("ar_ready rose while a read response was pending");
         check_data("held r data", model[ra[11:2]], core_rsp.r);
      end
      @(posedge clk);
      #2;
      core_req.r_ready = 1'b1;
      @(posedge clk);
      #2;
      core_req.r_ready = 1'b0;
      check_data("stalled read", model[ra[11:2]], held);

      // data channel three cycles behind the address
      wa = 32'h0000_0340;
      data = $urandom();
      axi_write(wa, data, 4'hF, 3, wb);
      check_resp("split write", B_OKAY, wb);
      model[wa[11:2]] = data;
      ram_check(wa);

      // read and write started in the same cycle
      wa = 32'h0000_0384;
      data = $urandom();
      fork
         axi_read(ra, rd);
         axi_write(wa, data, 4'hF, 0, wb);
      join
      check_data("concurrent read", model[ra[11:2]], rd);
      check_resp("concurrent read", B_OKAY, axi_b_t'(rd.resp));
      check_resp("concurrent write", B_OKAY, wb);
      model[wa[11:2]] = data;
      ram_check(wa);
   endtask

   ////////////////////
   // run control

   initial begin
      void'($urandom(52863));
      core_req = '0;
      rstn = 1'b1;
      loopback = 1'b0;
      rxd_drive = 1'b1;
      n_checks = 0;
      n_errors = 0;
      test_name = "reset";
      repeat (5) @(posedge clk);
      #2;
      rstn = 1'b0;
      reset_state();
      ram_strobes();
      address_decode();
      uart_loopback();
      uart_errors();
      bus_backpressure();
      $display("checks run: %0d, errors: %0d", n_checks, n_errors);
      if (n_errors == 0)
         $display("Simulation completed successfully");
      else
         $display("Simulation failed");
      $finish;
   end

   initial begin
      #(WATCHDOG_NS);
      $display("ERROR timeout: run still going after %0d ns in %s", WATCHDOG_NS, test_name);
      $display("Simulation failed");
      $finish;
   end

endmodule

`default_nettype wire

// File: uart_core.sv
`timescale 1ns/1ps
`default_nettype none

module uart_core
   import soc_bus_pkg::*;
(
   input  logic       clk,
   input  logic       rstn,
   input  uart_ctrl_t ctrl,
   output uart_stat_t stat,
   output logic       txd,
   input  logic       rxd
);

   logic                 tx_busy;
   logic [DIV_WIDTH-1:0] tx_cnt;
   logic [3:0]           tx_bit;
   logic [9:0]           tx_shift;

   logic [2:0]           rx_sync;
   logic                 rx_in;
   logic                 rx_fall;
   logic                 rx_busy;
   logic [DIV_WIDTH-1:0] rx_cnt;
   logic [3:0]           rx_bit;
   logic [7:0]           rx_shift;
   logic                 rx_strobe;
   logic                 rx_frame_err;

   ////////////////////
   // transmitter

   always_ff @(posedge clk) begin
      if (rstn) begin
         tx_busy <= 1'b0;
         tx_cnt <= '0;
         tx_bit <= '0;
         tx_shift <= '1;
      end else if (!tx_busy) begin
         if (ctrl.tx_start) begin
            tx_busy <= 1'b1;
            tx_cnt <= ctrl.divisor - 1'b1;
            tx_bit <= '0;
            // stop, data lsb first, start
            tx_shift <= {1'b1, ctrl.tx_byte, 1'b0};
         end
      end else if (tx_cnt != '0) begin
         tx_cnt <= tx_cnt - 1'b1;
      end else begin
         tx_cnt <= ctrl.divisor - 1'b1;
         tx_shift <= {1'b1, tx_shift[9:1]};
         tx_bit <= tx_bit + 1'b1;
         if (tx_bit == 4'd9)
            tx_busy <= 1'b0;
      end
   end

   assign txd = tx_busy ? tx_shift[0] : 1'b1;

   ////////////////////
   // receiver

   assign rx_in   = rx_sync[1];
   assign rx_fall = rx_sync[2] & !rx_sync[1];

   always_ff @(posedge clk) begin
      if (rstn) begin
         rx_sync <= '1;
         rx_busy <= 1'b0;
         rx_cnt <= '0;
         rx_bit <= '0;
         rx_strobe <= 1'b0;
         rx_frame_err <= 1'b0;
      end else begin
         rx_sync <= {rx_sync[1:0], rxd};
         rx_strobe <= 1'b0;
         rx_frame_err <= 1'b0;
         if (!rx_busy) begin
            if (rx_fall) begin
               rx_busy <= 1'b1;
               rx_bit <= '0;
               // half a bit to reach mid start bit
               rx_cnt <= ctrl.divisor >> 1;
            end
         end else if (rx_cnt != '0) begin
            rx_cnt <= rx_cnt - 1'b1;
         end else begin
            rx_cnt <= ctrl.divisor - 1'b1;
            rx_bit <= rx_bit + 1'b1;
            if (rx_bit == 4'd0 && rx_in)
               rx_busy <= 1'b0;
            if (rx_bit == 4'd9) begin
               rx_busy <= 1'b0;
               rx_strobe <= 1'b1;
               rx_frame_err <= !rx_in;
            end
         end
      end
   end

   // data bits shift in lsb first
   always_ff @(posedge clk) begin
      if (rx_busy && rx_cnt == '0 && rx_bit >= 4'd1 && rx_bit <= 4'd8)
         rx_shift <= {rx_in, rx_shift[7:1]};
   end

   always_comb begin
      stat.tx_busy      = tx_busy;
      stat.rx_strobe    = rx_strobe;
      stat.rx_byte      = rx_shift;
      stat.rx_frame_err = rx_frame_err;
   end

endmodule

`default_nettype wire

// File: uart_regs.sv
`timescale 1ns/1ps
`default_nettype none

module uart_regs
   import soc_bus_pkg::*;
(
   input  logic       clk,
   input  logic       rstn,
   input  axi_req_t   req,
   output axi_rsp_t   rsp,
   output uart_ctrl_t ctrl,
   input  uart_stat_t stat
);

   logic       r_pend;
   logic       b_pend;
   logic       aw_hold;
   logic       w_hold;
   logic       ar_fire;
   logic       aw_fire;
   logic       w_fire;
   logic       wr_go;
   logic       rx_take;
   logic       tx_free;
   logic [3:0] aw_sel;
   axi_w_t     w_buf;
   axi_r_t     r_buf;
   axi_b_t     b_buf;
   logic [7:0] rx_byte;
   logic       rx_valid;
   logic       overrun;
   logic       frame_err;

   assign ar_fire = req.ar_valid & rsp.ar_ready;
   assign aw_fire = req.aw_valid & rsp.aw_ready;
   assign w_fire  = req.w_valid & rsp.w_ready;
   assign wr_go   = aw_hold & w_hold;
   assign rx_take = ar_fire & (req.ar.addr[3:0] == UART_REG_RX) & rx_valid;
   assign tx_free = !stat.tx_busy & !ctrl.tx_start;

   always_ff @(posedge clk) begin
      if (rstn) begin
         r_pend <= 1'b0;
         b_pend <= 1'b0;
         aw_hold <= 1'b0;
         w_hold <= 1'b0;
         ctrl <= '{divisor: DEFAULT_DIVISOR, tx_start: 1'b0, tx_byte: 8'd0};
         rx_valid <= 1'b0;
         overrun <= 1'b0;
         frame_err <= 1'b0;
      end else begin
         ctrl.tx_start <= 1'b0;
         if (ar_fire)
            r_pend <= 1'b1;
         else if (req.r_ready)
            r_pend <= 1'b0;
         if (aw_fire)
            aw_hold <= 1'b1;
         if (w_fire)
            w_hold <= 1'b1;
         if (wr_go) begin
            aw_hold <= 1'b0;
            w_hold <= 1'b0;
            b_pend <= 1'b1;
            if (aw_sel == UART_REG_TX && tx_free) begin
               ctrl.tx_start <= 1'b1;
               ctrl.tx_byte <= w_buf.data[7:0];
            end
            if (aw_sel == UART_REG_CTRL)
               ctrl.divisor <= w_buf.data[DIV_WIDTH-1:0];
         end else if (req.b_ready) begin
            b_pend <= 1'b0;
         end

         // reading RX clears the flags, a new byte still wins
         if (rx_take) begin
            rx_valid <= 1'b0;
            overrun <= 1'b0;
            frame_err <= 1'b0;
         end
         if (stat.rx_strobe) begin
            rx_valid <= 1'b1;
            if (rx_valid && !rx_take)
               overrun <= 1'b1;
            if (stat.rx_frame_err)
               frame_err <= 1'b1;
         end
      end
   end

   always_ff @(posedge clk) begin
      if (stat.rx_strobe)
         rx_byte <= stat.rx_byte;
      if (aw_fire)
         aw_sel <= req.aw.addr[3:0];
      if (w_fire)
         w_buf <= req.w;
      if (wr_go) begin
         b_buf.resp <= RESP_SLVERR;
         if ((aw_sel == UART_REG_TX && tx_free) || aw_sel == UART_REG_CTRL)
            b_buf.resp <= RESP_OKAY;
      end
      if (ar_fire) begin
         r_buf.data <= '0;
         r_buf.resp <= RESP_OKAY;
         case (req.ar.addr[3:0])
            UART_REG_RX: begin
               r_buf.data <= {24'd0, rx_byte};
               if (!rx_valid)
                  r_buf.resp <= RESP_SLVERR;
            end
            UART_REG_STATUS: r_buf.data <= {28'd0, overrun, frame_err, rx_valid, stat.tx_busy};
            UART_REG_CTRL: r_buf.data <= {{(32-DIV_WIDTH){1'b0}}, ctrl.divisor};
            default: r_buf.resp <= RESP_SLVERR;
         endcase
      end
   end

   always_comb begin
      rsp.ar_ready = !r_pend;
      rsp.aw_ready = !aw_hold & !b_pend;
      rsp.w_ready  = !w_hold & !b_pend;
      rsp.r_valid  = r_pend;
      rsp.r        = r_buf;
      rsp.b_valid  = b_pend;
      rsp.b        = b_buf;
   end

endmodule

`default_nettype wire
